// ==== vlog.f ====
hdl/mcpu_pkg.sv
hdl/mcpu_regfile.sv
hdl/mcpu_alu.sv
hdl/mcpu_decoder.sv
hdl/mcpu_ctrl.sv
hdl/mcpu_datapath.sv
hdl/mcpu_top.sv
testbench/tb_clkgen.sv
testbench/mcpu_chk.sv
testbench/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_top -o tb_top_sim
./obj_dir/tb_top_sim +verilator+error+limit+100 | tee sim.log

if grep -qx ">>> PASS" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// ==== testbench/tb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_top
    import mcpu_pkg::*;
();

    localparam int CLK_NS    = 20;
    localparam int RUN_LIMIT = 200 * 5;
    localparam int NUM_RUNS  = 6;
    localparam logic [5:0] RR_FNS [10] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT,
                                          FN_SLTU, FN_AND, FN_OR, FN_XOR, FN_NOR};

    logic       clk;
    logic       por_rst;
    logic       rst_req = 1'b0;
    logic       tb_rst = 1'b0;
    logic       resetn;
    logic       inst_sram_en;
    word_t      inst_sram_addr;
    word_t      inst_rdata = '0;
    logic       data_sram_en;
    logic [3:0] data_sram_wen;
    word_t      data_sram_addr;
    word_t      data_sram_wdata;
    word_t      data_rdata = '0;
    word_t      debug_wb_pc;
    logic       debug_wb_rf_wen;
    reg_idx_t   debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    word_t      imem [1024];
    word_t      dmem [1024];
    word_t      st_addr = '0;
    word_t      st_data = '0;
    logic [3:0] st_wen = '0;

    word_t act_num [$];
    word_t act_data [$];
    word_t act_pc [$];
    word_t exp_num [$];
    word_t exp_data [$];
    word_t exp_pc [$];
    int    act_base = 0;
    word_t pc_ptr = '0;
    int    errors = 0;
    int    checks = 0;

    tb_clkgen clkgen_i (
        .clk    (clk),
        .resetn (por_rst)
    );

    assign resetn = por_rst | tb_rst;

    mcpu_top dut_i (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always @(posedge clk) begin
        tb_rst <= rst_req;
    end

    // both srams answer one cycle after the address
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_rdata <= imem[inst_sram_addr[11:2]];
        end
        if (data_sram_en) begin
            if (data_sram_wen != 4'b0000) begin
                dmem[data_sram_addr[11:2]] <= data_sram_wdata;
                st_addr <= data_sram_addr;
                st_data <= data_sram_wdata;
                st_wen  <= data_sram_wen;
            end else begin
                data_rdata <= dmem[data_sram_addr[11:2]];
            end
        end
    end

    // writeback monitor
    always @(negedge clk) begin
        if (!resetn && debug_wb_rf_wen) begin
            act_num.push_back({27'd0, debug_wb_rf_wnum});
            act_data.push_back(debug_wb_rf_wdata);
            act_pc.push_back(debug_wb_pc);
        end
    end

    function automatic word_t enc_r(logic [5:0] fn, int rs, int rt, int rd);
        return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic word_t enc_i(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic word_t enc_j(word_t target);
        return {OP_J, target[27:2]};
    endfunction

    // expected result of a reg-reg function
    function automatic word_t alu_ref(logic [5:0] fn, word_t a, word_t b);
        case (fn)
            FN_ADD, FN_ADDU: return a + b;
            FN_SUB, FN_SUBU: return a - b;
            FN_SLT:          return {31'd0, $signed(a) < $signed(b)};
            FN_SLTU:         return {31'd0, a < b};
            FN_AND:          return a & b;
            FN_OR:           return a | b;
            FN_XOR:          return a ^ b;
            default:         return ~(a | b);
        endcase
    endfunction

    task automatic check(input word_t actual, input word_t expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic emit(input word_t inst);
        imem[pc_ptr[11:2]] = inst;
        pc_ptr = pc_ptr + 32'd4;
    endtask

    task automatic emit_wr(input word_t inst, input int num, input word_t data);
        exp_num.push_back(num);
        exp_data.push_back(data);
        exp_pc.push_back(pc_ptr);
        emit(inst);
    endtask

    task automatic load_reg(input int r, input word_t v);
        emit_wr(enc_i(OP_LUI, 0, r, v[31:16]), r, {v[31:16], 16'h0000});
        emit_wr(enc_i(OP_ORI, r, r, v[15:0]), r, v);
    endtask

    task automatic begin_test();
        @(negedge clk);
        rst_req = 1'b1;
        @(negedge clk);
        act_base = act_num.size();
        exp_num.delete();
        exp_data.delete();
        exp_pc.delete();
        pc_ptr = '0;
    endtask

    task automatic check_reset_outputs(input string when);
        check({31'd0, debug_wb_rf_wen}, '0, {when, ": debug write enable"});
        check({31'd0, data_sram_en}, '0, {when, ": data sram enable"});
        check(inst_sram_addr, RESET_PC, {when, ": instruction address"});
    endtask

    // ends the program in a self-loop, releases reset and waits for the loop
    task automatic run_program(input string name);
        word_t loop_addr;
        bit    done;
        loop_addr = pc_ptr;
        emit(enc_j(loop_addr));
        done = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_reset_outputs({name, " in reset"});
        end
        rst_req = 1'b0;
        @(negedge clk);
        check_reset_outputs({name, " after reset"});
        check({31'd0, inst_sram_en}, 32'd1, {name, " after reset: instruction sram enable"});
        for (int cyc = 0; cyc < RUN_LIMIT && !done; cyc++) begin
            @(negedge clk);
            check({31'd0, inst_sram_en}, 32'd1, {name, ": instruction sram enable"});
            done = (inst_sram_addr == loop_addr);
        end
        if (!done) begin
            errors++;
            $display("%s: the program never reached its final self-loop", name);
        end
        check(act_num.size() - act_base, exp_num.size(), {name, ": write count"});
        for (int i = 0; i < exp_num.size() && act_base + i < act_num.size(); i++) begin
            check(act_num[act_base + i], exp_num[i], $sformatf("%s: write %0d reg", name, i));
            check(act_data[act_base + i], exp_data[i], $sformatf("%s: write %0d data", name, i));
            check(act_pc[act_base + i], exp_pc[i], $sformatf("%s: write %0d pc", name, i));
        end
    endtask

    task automatic test_reset();
        begin_test();
        emit_wr(enc_i(OP_ORI, 0, 1, 16'h5a5a), 1, 32'h0000_5a5a);
        run_program("reset");
    endtask

    task automatic test_reg_reg(input bit signs_differ);
        word_t a;
        word_t b;
        begin_test();
        a = $urandom;
        b = $urandom;
        if (signs_differ) begin
            // negative against positive splits slt from sltu
            a[31] = 1'b1;
            b[31] = 1'b0;
        end
        load_reg(1, a);
        load_reg(2, b);
        for (int i = 0; i < 10; i++) begin
            emit_wr(enc_r(RR_FNS[i], 1, 2, 3 + i), 3 + i, alu_ref(RR_FNS[i], a, b));
        end
        emit_wr(enc_r(FN_ADD, 1, 2, 0), 0, a + b);
        // r0 still reads zero
        emit_wr(enc_r(FN_OR, 0, 0, 20), 20, '0);
        run_program("reg-reg");
    endtask

    task automatic test_immediate();
        word_t a;
        word_t imm;
        word_t sx;
        word_t zx;
        begin_test();
        a = $urandom;
        imm = $urandom;
        imm[15] = 1'b1;
        sx = {{16{imm[15]}}, imm[15:0]};
        zx = {16'h0000, imm[15:0]};
        load_reg(1, a);
        emit_wr(enc_i(OP_ADDI, 1, 2, imm[15:0]), 2, a + sx);
        emit_wr(enc_i(OP_ADDIU, 1, 3, imm[15:0]), 3, a + sx);
        emit_wr(enc_i(OP_SLTI, 1, 4, imm[15:0]), 4, {31'd0, $signed(a) < $signed(sx)});
        emit_wr(enc_i(OP_SLTIU, 1, 5, imm[15:0]), 5, {31'd0, a < sx});
        emit_wr(enc_i(OP_ANDI, 1, 6, imm[15:0]), 6, a & zx);
        emit_wr(enc_i(OP_ORI, 1, 7, imm[15:0]), 7, a | zx);
        emit_wr(enc_i(OP_XORI, 1, 8, imm[15:0]), 8, a ^ zx);
        emit_wr(enc_i(OP_LUI, 0, 9, imm[15:0]), 9, {imm[15:0], 16'h0000});
        run_program("immediate");
    endtask

    task automatic test_memory();
        word_t base;
        word_t data;
        word_t addr;
        begin_test();
        base = 32'h0000_0100 + ($urandom & 32'h0000_03f0);
        data = $urandom;
        // offset of -8 from the base
        addr = base - 32'd8;
        load_reg(1, base);
        load_reg(2, data);
        emit(enc_i(OP_SW, 1, 2, 16'hfff8));
        emit_wr(enc_i(OP_LW, 1, 3, 16'hfff8), 3, data);
        run_program("memory");
        check(st_addr, addr, "memory: store address");
        check(st_data, data, "memory: store data");
        check({28'd0, st_wen}, 32'h0000_000f, "memory: store byte enables");
        check(dmem[addr[11:2]], data, "memory: stored word");
    endtask

    // skipped instructions write r10, r13, r14 and r17, which must never show up
    task automatic test_control_flow();
        word_t v;
        begin_test();
        v = $urandom;
        load_reg(1, v);
        load_reg(2, v);
        load_reg(3, v ^ 32'h0001_0000);
        emit(enc_i(OP_BEQ, 1, 2, 16'h0001));
        emit(enc_i(OP_ORI, 0, 10, 16'h0bad));
        emit_wr(enc_i(OP_ORI, 0, 11, 16'h0011), 11, 32'h0000_0011);
        emit(enc_i(OP_BEQ, 1, 3, 16'h0001));
        emit_wr(enc_i(OP_ORI, 0, 12, 16'h0012), 12, 32'h0000_0012);
        emit(enc_i(OP_BNE, 1, 3, 16'h0002));
        emit(enc_i(OP_ORI, 0, 13, 16'h0bad));
        emit(enc_i(OP_ORI, 0, 14, 16'h0bad));
        emit_wr(enc_i(OP_ORI, 0, 15, 16'h0015), 15, 32'h0000_0015);
        emit(enc_i(OP_BNE, 1, 2, 16'h0001));
        emit_wr(enc_i(OP_ORI, 0, 16, 16'h0016), 16, 32'h0000_0016);
        emit(enc_j(pc_ptr + 32'd8));
        emit(enc_i(OP_ORI, 0, 17, 16'h0bad));
        emit_wr(enc_i(OP_ORI, 0, 18, 16'h0018), 18, 32'h0000_0018);
        run_program("control flow");
    endtask

    initial begin
        void'($urandom(16));
        test_reset();
        test_reg_reg(1'b0);
        test_reg_reg(1'b1);
        test_immediate();
        test_memory();
        test_control_flow();
        $display("%0d checks, %0d errors, %0d assertion failures",
                 checks, errors, dut_i.chk_i.fails);
        if (errors == 0 && dut_i.chk_i.fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // each run is bounded by its wait loop plus a few reset cycles
    initial begin
        #(NUM_RUNS * (RUN_LIMIT + 10) * CLK_NS);
        $display("watchdog expired, the tests did not finish in time");
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/mcpu_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module mcpu_chk
    import mcpu_pkg::*;
(
    input logic       clk,
    input logic       resetn,
    input cpu_state_e state,
    input word_t      ir,
    input logic       data_sram_en,
    input logic [3:0] data_sram_wen,
    input logic       debug_wb_rf_wen,
    input reg_idx_t   debug_wb_rf_wnum
);

    int unsigned fails = 0;
    reg_idx_t    target;

    // destination field as encoded, rd for the special opcode, rt otherwise
    assign target = (ir[31:26] == OP_SPECIAL) ? ir[15:11] : ir[20:16];

    a_wen_needs_en: assert property (@(posedge clk) disable iff (resetn)
        data_sram_wen != 4'b0000 |-> data_sram_en)
        else begin
            fails++;
            $error("data sram write strobe without enable");
        end

    a_no_wb_early: assert property (@(posedge clk) disable iff (resetn)
        debug_wb_rf_wen |-> !(state inside {S_FETCH, S_DECODE}))
        else begin
            fails++;
            $error("register write during fetch or decode");
        end

    a_r0_only_on_purpose: assert property (@(posedge clk) disable iff (resetn)
        debug_wb_rf_wen && debug_wb_rf_wnum == 5'd0 |-> target == 5'd0)
        else begin
            fails++;
            $error("write to r0 from an instruction that names another register");
        end

endmodule

bind mcpu_top mcpu_chk chk_i (
    .clk              (clk),
    .resetn           (resetn),
    .state            (state),
    .ir               (ir),
    .data_sram_en     (data_sram_en),
    .data_sram_wen    (data_sram_wen),
    .debug_wb_rf_wen  (debug_wb_rf_wen),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

`default_nettype wire

// ==== testbench/tb_clkgen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
    parameter int HALF_PERIOD = 10
) (
    output logic clk,
    output logic resetn
);

    logic [2:0] rst_cnt = 3'd0;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // power-on reset, released at the fourth rising edge
    always @(posedge clk) begin
        if (rst_cnt != 3'd4) begin
            rst_cnt <= rst_cnt + 3'd1;
        end
    end

    assign resetn = (rst_cnt != 3'd4);

endmodule

`default_nettype wire

// ==== hdl/mcpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mcpu_top
    import mcpu_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,

    output logic       inst_sram_en,
    output word_t      inst_sram_addr,
    input  word_t      inst_sram_rdata,

    output logic       data_sram_en,
    output logic [3:0] data_sram_wen,
    output word_t      data_sram_addr,
    output word_t      data_sram_wdata,
    input  word_t      data_sram_rdata,

    output word_t      debug_wb_pc,
    output logic       debug_wb_rf_wen,
    output reg_idx_t   debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    word_t      ir;
    dec_t       dec;
    ctl_t       ctl;
    cpu_state_e state;

    mcpu_decoder decoder_i (
        .ir  (ir),
        .dec (dec)
    );

    mcpu_ctrl ctrl_i (
        .clk    (clk),
        .resetn (resetn),
        .dec    (dec),
        .state  (state),
        .ctl    (ctl)
    );

    mcpu_datapath datapath_i (
        .clk        (clk),
        .resetn     (resetn),
        .dec        (dec),
        .ctl        (ctl),
        .inst_rdata (inst_sram_rdata),
        .data_rdata (data_sram_rdata),
        .pc         (inst_sram_addr),
        .ir         (ir),
        .dm_addr    (data_sram_addr),
        .dm_wdata   (data_sram_wdata),
        .wb_en      (debug_wb_rf_wen),
        .wb_idx     (debug_wb_rf_wnum),
        .wb_data    (debug_wb_rf_wdata)
    );

    // instruction sram is read every cycle, no handshake
    assign inst_sram_en  = 1'b1;
    assign data_sram_en  = ctl.dm_en;
    assign data_sram_wen = {4{ctl.dm_wr}};

    // pc is held until the retiring state, so it names the writer
    assign debug_wb_pc = inst_sram_addr;

endmodule

`default_nettype wire

// ==== hdl/mcpu_datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module mcpu_datapath
    import mcpu_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  dec_t     dec,
    input  ctl_t     ctl,
    input  word_t    inst_rdata,
    input  word_t    data_rdata,
    output word_t    pc,
    output word_t    ir,
    output word_t    dm_addr,
    output word_t    dm_wdata,
    output logic     wb_en,
    output reg_idx_t wb_idx,
    output word_t    wb_data
);

    word_t ir_q;
    word_t opnd_a;
    word_t opnd_b;
    word_t res_q;
    word_t rd_data1;
    word_t rd_data2;
    word_t imm_ext;
    word_t alu_b;
    word_t alu_y;
    logic  alu_zero;
    word_t pc_plus4;
    word_t br_off;
    word_t pc_nxt;
    logic  br_taken;

    // sram data is valid in decode, pass it straight through that cycle
    assign ir = ctl.ir_wr ? inst_rdata : ir_q;

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            ir_q <= '0;
        end else if (ctl.ir_wr) begin
            ir_q <= inst_rdata;
        end
    end

    mcpu_regfile regfile_i (
        .clk      (clk),
        .resetn   (resetn),
        .rf_wr    (wb_en),
        .wr_idx   (wb_idx),
        .wr_data  (wb_data),
        .rd_idx1  (ir[25:21]),
        .rd_idx2  (ir[20:16]),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

    // operand and result registers
    always_ff @(posedge clk) begin
        if (ctl.opnd_wr) begin
            opnd_a <= rd_data1;
            opnd_b <= rd_data2;
        end
        if (ctl.res_wr) begin
            res_q <= alu_y;
        end
    end

    assign imm_ext = dec.imm_zero_ext ? {16'd0, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
    assign alu_b   = dec.use_imm ? imm_ext : opnd_b;

    mcpu_alu alu_i (
        .a    (opnd_a),
        .b    (alu_b),
        .op   (dec.alu_op),
        .y    (alu_y),
        .zero (alu_zero)
    );

    // write-back source
    always_comb begin
        case (dec.inst_class)
            CLS_LUI:  wb_data = {ir[15:0], 16'd0};
            CLS_LOAD: wb_data = data_rdata;
            default:  wb_data = res_q;
        endcase
    end

    assign wb_en  = ctl.rf_wr;
    assign wb_idx = dec.dest;

    assign dm_addr  = res_q;
    assign dm_wdata = opnd_b;

    // next pc
    assign pc_plus4 = pc + 32'd4;
    assign br_off   = {{14{ir[15]}}, ir[15:0], 2'b00};
    assign br_taken = alu_zero ^ dec.branch_ne;

    always_comb begin
        case (dec.npc_sel)
            NPC_BRANCH: pc_nxt = br_taken ? pc_plus4 + br_off : pc_plus4;
            NPC_JUMP:   pc_nxt = {pc_plus4[31:28], ir[25:0], 2'b00};
            default:    pc_nxt = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            pc <= RESET_PC;
        end else if (ctl.pc_wr) begin
            pc <= pc_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mcpu_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module mcpu_ctrl
    import mcpu_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  dec_t       dec,
    output cpu_state_e state,
    output ctl_t       ctl
);

    cpu_state_e state_nxt;

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            state <= S_FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = S_FETCH;
        case (state)
            S_FETCH: state_nxt = S_DECODE;
            S_DECODE: begin
                case (dec.inst_class)
                    CLS_ALU:              state_nxt = S_ALU_EXE;
                    CLS_LUI:              state_nxt = S_LUI_WB;
                    CLS_LOAD, CLS_STORE:  state_nxt = S_MEM_ADDR;
                    CLS_BRANCH, CLS_JUMP: state_nxt = S_BRANCH_EXE;
                    default:              state_nxt = S_FETCH;
                endcase
            end
            S_ALU_EXE: state_nxt = S_ALU_WB;
            S_MEM_ADDR: begin
                state_nxt = (dec.inst_class == CLS_LOAD) ? S_MEM_LOAD : S_MEM_STORE;
            end
            S_MEM_LOAD: state_nxt = S_MEM_WB;
            // every write-back or exe state ends the instruction
            default: state_nxt = S_FETCH;
        endcase
    end

    always_comb begin
        ctl = '0;
        case (state)
            S_DECODE: begin
                ctl.ir_wr   = 1'b1;
                ctl.opnd_wr = 1'b1;
                // nop and unknown encodings retire here
                ctl.pc_wr   = (dec.inst_class == CLS_NONE);
            end
            S_ALU_EXE, S_MEM_ADDR: ctl.res_wr = 1'b1;
            S_ALU_WB, S_LUI_WB, S_MEM_WB: begin
                ctl.rf_wr = 1'b1;
                ctl.pc_wr = 1'b1;
            end
            S_MEM_LOAD: ctl.dm_en = 1'b1;
            S_MEM_STORE: begin
                ctl.dm_en = 1'b1;
                ctl.dm_wr = 1'b1;
                ctl.pc_wr = 1'b1;
            end
            S_BRANCH_EXE: ctl.pc_wr = 1'b1;
            default: ctl = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/mcpu_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module mcpu_decoder
    import mcpu_pkg::*;
(
    input  word_t ir,
    output dec_t  dec
);

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_idx_t   rt;
    reg_idx_t   rd;

    assign opcode = ir[31:26];
    assign funct  = ir[5:0];
    assign rt     = ir[20:16];
    assign rd     = ir[15:11];

    always_comb begin
        dec            = '0;
        dec.inst_class = CLS_NONE;
        dec.alu_op     = ALU_ADD;
        dec.npc_sel    = NPC_SEQ;
        // immediate forms write rt
        dec.dest       = rt;
        case (opcode)
            OP_SPECIAL: begin
                dec.dest       = rd;
                dec.inst_class = CLS_ALU;
                case (funct)
                    FN_ADD, FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_SLT:          dec.alu_op = ALU_SLT;
                    FN_SLTU:         dec.alu_op = ALU_SLTU;
                    FN_AND:          dec.alu_op = ALU_AND;
                    FN_OR:           dec.alu_op = ALU_OR;
                    FN_XOR:          dec.alu_op = ALU_XOR;
                    FN_NOR:          dec.alu_op = ALU_NOR;
                    // shifts, mult/div and the rest fall through as nop
                    default:         dec.inst_class = CLS_NONE;
                endcase
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                dec.inst_class = CLS_ALU;
                dec.use_imm    = 1'b1;
                if (opcode == OP_SLTI) begin
                    dec.alu_op = ALU_SLT;
                end else if (opcode == OP_SLTIU) begin
                    dec.alu_op = ALU_SLTU;
                end
            end
            OP_ANDI, OP_ORI, OP_XORI: begin
                dec.inst_class   = CLS_ALU;
                dec.use_imm      = 1'b1;
                dec.imm_zero_ext = 1'b1;
                dec.alu_op       = (opcode == OP_ANDI) ? ALU_AND :
                                   (opcode == OP_ORI)  ? ALU_OR  : ALU_XOR;
            end
            OP_LUI:  dec.inst_class = CLS_LUI;
            OP_LW, OP_SW: begin
                dec.inst_class = (opcode == OP_LW) ? CLS_LOAD : CLS_STORE;
                dec.use_imm    = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                // equality test through the subtractor
                dec.inst_class = CLS_BRANCH;
                dec.alu_op     = ALU_SUB;
                dec.branch_ne  = (opcode == OP_BNE);
                dec.npc_sel    = NPC_BRANCH;
            end
            OP_J: begin
                dec.inst_class = CLS_JUMP;
                dec.npc_sel    = NPC_JUMP;
            end
            default: dec.inst_class = CLS_NONE;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/mcpu_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module mcpu_alu
    import mcpu_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output word_t   y,
    output logic    zero
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_SLT:  y = {31'd0, lt_signed};
            ALU_SLTU: y = {31'd0, lt_unsigned};
            ALU_AND:  y = a & b;
            ALU_OR:   y = a | b;
            ALU_XOR:  y = a ^ b;
            ALU_NOR:  y = ~(a | b);
            default:  y = a + b;
        endcase
    end

    // used for beq/bne after sub
    assign zero = (y == '0);

endmodule

`default_nettype wire

// ==== hdl/mcpu_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module mcpu_regfile
    import mcpu_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  logic     rf_wr,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data,
    input  reg_idx_t rd_idx1,
    input  reg_idx_t rd_idx2,
    output word_t    rd_data1,
    output word_t    rd_data2
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or posedge resetn) begin
        if (resetn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wr && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // r0 is hardwired to zero
    assign rd_data1 = (rd_idx1 == '0) ? '0 : regs[rd_idx1];
    assign rd_data2 = (rd_idx2 == '0) ? '0 : regs[rd_idx2];

endmodule

`default_nettype wire

// ==== hdl/mcpu_pkg.sv ====
`default_nettype none

package mcpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    localparam word_t RESET_PC = 32'h0000_0000;
    localparam int    NUM_REGS = 32;

    // primary opcodes, ir[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // function codes of the special opcode, ir[5:0]
    localparam logic [5:0] FN_ADD  = 6'h20;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUB  = 6'h22;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR
    } alu_op_e;

    typedef enum logic [3:0] {
        S_FETCH, S_DECODE, S_ALU_EXE, S_ALU_WB, S_LUI_WB,
        S_MEM_ADDR, S_MEM_LOAD, S_MEM_WB, S_MEM_STORE, S_BRANCH_EXE
    } cpu_state_e;

    typedef enum logic [2:0] {
        CLS_ALU, CLS_LUI, CLS_LOAD, CLS_STORE, CLS_BRANCH, CLS_JUMP, CLS_NONE
    } inst_class_e;

    typedef enum logic [1:0] {
        NPC_SEQ, NPC_BRANCH, NPC_JUMP
    } npc_sel_e;

    typedef struct packed {
        inst_class_e inst_class;
        alu_op_e     alu_op;
        logic        use_imm;
        logic        imm_zero_ext;
        logic        branch_ne;
        npc_sel_e    npc_sel;
        reg_idx_t    dest;
    } dec_t;

    typedef struct packed {
        logic ir_wr;
        logic opnd_wr;
        logic res_wr;
        logic pc_wr;
        logic rf_wr;
        logic dm_en;
        logic dm_wr;
    } ctl_t;

endpackage

`default_nettype wire
